/* design/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W    = 32;
    localparam int BLOCK_W   = 64;
    localparam int OFFSET_W  = 3;  // byte offset inside one line
    localparam int MEM_TAG_W = 4;  // zero tag means no response

    // memory port command
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } mem_cmd_t;

    // access size of a pipeline request
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_t;

    // one cache line, read as bytes, halves or words
    typedef union packed {
        logic [BLOCK_W/8-1:0][7:0]   byte_level;
        logic [BLOCK_W/16-1:0][15:0] half_level;
        logic [BLOCK_W/32-1:0][31:0] word_level;
    } cache_block_t;

endpackage

/* design/line_fill_if.sv */
`timescale 1ns/10ps

interface line_fill_if #(
    parameter int N_LINES = 32
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(N_LINES);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    // line fill from the memory side
    logic                 fill_valid;
    logic [INDEX_W-1:0]   fill_index;
    logic [TAG_W-1:0]     fill_tag;
    logic [BLOCK_W-1:0]   fill_block;

    logic [INDEX_W-1:0]   probe_index;  // victim or flush walk read
    logic                 invalidate;   // clears the probed line

    // held request played back after a fill
    logic                 replay_valid;
    logic                 replay_write;
    mem_size_t            replay_size;
    logic [ADDR_W-1:0]    replay_addr;
    logic [31:0]          replay_wdata;

    // lookup result, the request comes along so a miss can be captured
    logic                 lookup_valid;
    logic                 lookup_hit;
    logic                 miss_write;
    mem_size_t            miss_size;
    logic [ADDR_W-1:0]    miss_addr;
    logic [31:0]          miss_wdata;

    // contents of the probed line
    logic                 probe_valid;
    logic                 probe_dirty;
    logic [TAG_W-1:0]     probe_tag;
    logic [BLOCK_W-1:0]   probe_block;

    modport handler (
        output fill_valid, fill_index, fill_tag, fill_block,
        output probe_index, invalidate,
        output replay_valid, replay_write, replay_size, replay_addr, replay_wdata,
        input  lookup_valid, lookup_hit, miss_write, miss_size, miss_addr, miss_wdata,
        input  probe_valid, probe_dirty, probe_tag, probe_block
    );

    modport store (
        input  fill_valid, fill_index, fill_tag, fill_block,
        input  probe_index, invalidate,
        input  replay_valid, replay_write, replay_size, replay_addr, replay_wdata,
        output lookup_valid, lookup_hit, miss_write, miss_size, miss_addr, miss_wdata,
        output probe_valid, probe_dirty, probe_tag, probe_block
    );

endinterface

/* design/line_store.sv */
`timescale 1ns/10ps

module line_store #(
    parameter int N_LINES = 32
) (
    input  logic                              clock,
    input  logic                              reset,

    input  logic                              req_valid,
    input  logic                              req_write,
    input  dcache_pkg::mem_size_t             req_size,
    input  logic [dcache_pkg::ADDR_W-1:0]     req_addr,
    input  logic [31:0]                       req_wdata,
    input  logic                              stall,

    line_fill_if.store                        fill,

    output logic                              hit,
    output dcache_pkg::cache_block_t          block,
    output logic [dcache_pkg::OFFSET_W-1:0]   offset,
    output dcache_pkg::mem_size_t             size,
    output logic                              write
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(N_LINES);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    logic [N_LINES-1:0]  valid_q;
    logic [N_LINES-1:0]  dirty_q;
    logic [TAG_W-1:0]    tag_q [N_LINES];
    cache_block_t        data_q [N_LINES];

    logic                sel_valid;
    logic                sel_write;
    mem_size_t           sel_size;
    logic [ADDR_W-1:0]   sel_addr;
    logic [31:0]         sel_wdata;
    logic [INDEX_W-1:0]  sel_index;
    logic [TAG_W-1:0]    sel_tag;
    logic [OFFSET_W-1:0] sel_offset;
    cache_block_t        merged;

    // replay wins, pipeline requests are only looked at while not stalled
    always_comb begin
        if (fill.replay_valid) begin
            sel_valid = 1'b1;
            sel_write = fill.replay_write;
            sel_size  = fill.replay_size;
            sel_addr  = fill.replay_addr;
            sel_wdata = fill.replay_wdata;
        end else begin
            sel_valid = req_valid && !stall;
            sel_write = req_write;
            sel_size  = req_size;
            sel_addr  = req_addr;
            sel_wdata = req_wdata;
        end
    end

    assign sel_offset = sel_addr[OFFSET_W-1:0];
    assign sel_index  = sel_addr[OFFSET_W +: INDEX_W];
    assign sel_tag    = sel_addr[ADDR_W-1 -: TAG_W];

    assign hit = sel_valid && valid_q[sel_index] && (tag_q[sel_index] == sel_tag);

    // toward load_align
    assign block  = data_q[sel_index];
    assign offset = sel_offset;
    assign size   = sel_size;
    assign write  = sel_write;

    // lookup result and the request itself, for miss capture
    assign fill.lookup_valid = sel_valid;
    assign fill.lookup_hit   = hit;
    assign fill.miss_write   = sel_write;
    assign fill.miss_size    = sel_size;
    assign fill.miss_addr    = sel_addr;
    assign fill.miss_wdata   = sel_wdata;

    assign fill.probe_valid = valid_q[fill.probe_index];
    assign fill.probe_dirty = dirty_q[fill.probe_index];
    assign fill.probe_tag   = tag_q[fill.probe_index];
    assign fill.probe_block = data_q[fill.probe_index];

    // store data laid over the current line
    always_comb begin
        merged = data_q[sel_index];
        case (sel_size)
            BYTE:    merged.byte_level[sel_offset] = sel_wdata[7:0];
            HALF:    merged.half_level[sel_offset[OFFSET_W-1:1]] = sel_wdata[15:0];
            WORD:    merged.word_level[sel_offset[OFFSET_W-1]] = sel_wdata;
            default: merged = data_q[sel_index];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill.fill_valid) begin
                valid_q[fill.fill_index] <= 1'b1;  // fresh line is clean
                dirty_q[fill.fill_index] <= 1'b0;
            end
            if (hit && sel_write) begin
                dirty_q[sel_index] <= 1'b1;
            end
            if (fill.invalidate) begin
                valid_q[fill.probe_index] <= 1'b0;
                dirty_q[fill.probe_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill.fill_valid) begin
            tag_q[fill.fill_index]  <= fill.fill_tag;
            data_q[fill.fill_index] <= fill.fill_block;
        end else if (hit && sel_write) begin
            data_q[sel_index] <= merged;
        end
    end

    // a fill only happens while stalled, with no lookup in flight
    a_fill_excludes_hit: assert property (@(posedge clock) disable iff (reset)
        !(fill.fill_valid && hit));

endmodule

/* design/miss_handler.sv */
`timescale 1ns/10ps

module miss_handler #(
    parameter int N_LINES = 32
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 done,

    input  logic [dcache_pkg::MEM_TAG_W-1:0]     mem_response,
    input  logic [dcache_pkg::BLOCK_W-1:0]       mem_rdata,
    input  logic [dcache_pkg::MEM_TAG_W-1:0]     mem_tag,

    output logic                                 stall,
    output dcache_pkg::mem_cmd_t                 mem_command,
    output logic [dcache_pkg::ADDR_W-1:0]        mem_addr,
    output logic [dcache_pkg::BLOCK_W-1:0]       mem_wdata,
    output logic                                 flush_finished,

    line_fill_if.handler                         fill
);
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(N_LINES);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    typedef enum logic [2:0] {
        ST_READY,
        ST_WRITEBACK,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_REPLAY,
        ST_FLUSH_PROBE,
        ST_FLUSH_WRITE,
        ST_FINISHED
    } state_t;

    state_t                 state;
    state_t                 next_state;
    logic [INDEX_W-1:0]     walk_index;     // miss index, or flush position
    logic [MEM_TAG_W-1:0]   mem_tag_q;      // tag of the outstanding load

    // held miss request
    logic                   req_write_q;
    mem_size_t              req_size_q;
    logic [ADDR_W-1:0]      req_addr_q;
    logic [31:0]            req_wdata_q;

    logic                   miss;
    logic                   accepted;
    logic                   victim_dirty;
    logic                   fill_return;
    logic                   last_index;
    logic [ADDR_W-1:0]      victim_addr;

    assign miss         = (state == ST_READY) && fill.lookup_valid && !fill.lookup_hit;
    assign accepted     = (mem_response != '0);
    assign victim_dirty = fill.probe_valid && fill.probe_dirty;
    assign fill_return  = (state == ST_FILL_WAIT) && (mem_tag == mem_tag_q);
    assign last_index   = &walk_index;
    assign victim_addr  = {fill.probe_tag, walk_index, {OFFSET_W{1'b0}}};

    // in ready the victim is looked up at the missing request's index
    assign fill.probe_index = (state == ST_READY) ? fill.miss_addr[OFFSET_W +: INDEX_W]
                                                  : walk_index;

    always_comb begin
        next_state = state;
        case (state)
            ST_READY: begin
                if (miss) begin
                    next_state = victim_dirty ? ST_WRITEBACK : ST_FILL_REQ;
                end else if (done) begin
                    next_state = ST_FLUSH_PROBE;
                end
            end
            ST_WRITEBACK:   if (accepted) next_state = ST_FILL_REQ;
            ST_FILL_REQ:    if (accepted) next_state = ST_FILL_WAIT;
            ST_FILL_WAIT:   if (fill_return) next_state = ST_REPLAY;
            ST_REPLAY:      next_state = ST_READY;  // hit is resolved in this cycle
            ST_FLUSH_PROBE: begin
                if (victim_dirty) begin
                    next_state = ST_FLUSH_WRITE;
                end else if (last_index) begin
                    next_state = ST_FINISHED;
                end
            end
            ST_FLUSH_WRITE: begin
                if (accepted) begin
                    next_state = last_index ? ST_FINISHED : ST_FLUSH_PROBE;
                end
            end
            ST_FINISHED:    next_state = ST_FINISHED;  // held until reset
            default:        next_state = ST_READY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ST_READY;
            stall      <= 1'b0;
            walk_index <= '0;
            mem_tag_q  <= '0;
        end else begin
            state <= next_state;
            stall <= (next_state != ST_READY);
            if (miss) begin
                walk_index <= fill.miss_addr[OFFSET_W +: INDEX_W];
            end else if (state == ST_READY && done) begin
                walk_index <= '0;  // start of flush walk
            end else if ((state == ST_FLUSH_PROBE && !victim_dirty) ||
                         (state == ST_FLUSH_WRITE && accepted)) begin
                walk_index <= walk_index + 1'b1;
            end
            if (state == ST_FILL_REQ && accepted) begin
                mem_tag_q <= mem_response;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (miss) begin
            req_write_q <= fill.miss_write;
            req_size_q  <= fill.miss_size;
            req_addr_q  <= fill.miss_addr;
            req_wdata_q <= fill.miss_wdata;
        end
    end

    always_comb begin
        mem_command = BUS_NONE;
        mem_addr    = '0;
        mem_wdata   = '0;
        case (state)
            ST_WRITEBACK, ST_FLUSH_WRITE: begin
                mem_command = BUS_STORE;
                mem_addr    = victim_addr;
                mem_wdata   = fill.probe_block;
            end
            ST_FILL_REQ: begin
                mem_command = BUS_LOAD;
                mem_addr    = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned
            end
            default: ;
        endcase
    end

    assign fill.fill_valid = fill_return;
    assign fill.fill_index = walk_index;
    assign fill.fill_tag   = req_addr_q[ADDR_W-1 -: TAG_W];
    assign fill.fill_block = mem_rdata;

    // every flushed line is dropped, dirty ones after their store is taken
    assign fill.invalidate = (state == ST_FLUSH_PROBE && !victim_dirty) ||
                             (state == ST_FLUSH_WRITE && accepted);

    assign fill.replay_valid = (state == ST_REPLAY);
    assign fill.replay_write = req_write_q;
    assign fill.replay_size  = req_size_q;
    assign fill.replay_addr  = req_addr_q;
    assign fill.replay_wdata = req_wdata_q;

    assign flush_finished = (state == ST_FINISHED);

    // memory sees the same command until it hands out a tag
    a_cmd_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command != BUS_NONE && mem_response == '0) |=>
        ($stable(mem_command) && $stable(mem_addr) && $stable(mem_wdata)));

endmodule

/* design/load_align.sv */
`timescale 1ns/10ps

module load_align (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              hit,
    input  dcache_pkg::cache_block_t          block,
    input  logic [dcache_pkg::OFFSET_W-1:0]   offset,
    input  dcache_pkg::mem_size_t             size,
    input  logic                              write,
    output logic                              resp_valid,
    output logic [31:0]                       resp_data
);
    import dcache_pkg::*;

    logic [31:0] load_data;

    // pick the addressed piece, upper bits stay zero
    always_comb begin
        load_data = '0;
        if (!write) begin
            case (size)
                BYTE:    load_data[7:0]  = block.byte_level[offset];
                HALF:    load_data[15:0] = block.half_level[offset[OFFSET_W-1:1]];
                WORD:    load_data       = block.word_level[offset[OFFSET_W-1]];
                default: load_data       = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= hit;
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= load_data;  // stores give zero
    end

    // union views only line up for a known size at an aligned offset
    a_aligned_access: assert property (@(posedge clock) disable iff (reset)
        hit |-> (size != 2'h3) &&
                (size == BYTE || offset[0] == 1'b0) &&
                (size != WORD || offset[1:0] == 2'b00));

endmodule

/* design/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top #(
    parameter int N_LINES = 32
) (
    input  logic                                 clock,
    input  logic                                 reset,

    // pipeline side
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  dcache_pkg::mem_size_t                req_size,
    input  logic [dcache_pkg::ADDR_W-1:0]        req_addr,
    input  logic [31:0]                          req_wdata,
    output logic                                 stall,
    output logic                                 resp_valid,
    output logic [31:0]                          resp_data,

    // memory side
    output dcache_pkg::mem_cmd_t                 mem_command,
    output logic [dcache_pkg::ADDR_W-1:0]        mem_addr,
    output logic [dcache_pkg::BLOCK_W-1:0]       mem_wdata,
    input  logic [dcache_pkg::MEM_TAG_W-1:0]     mem_response,
    input  logic [dcache_pkg::BLOCK_W-1:0]       mem_rdata,
    input  logic [dcache_pkg::MEM_TAG_W-1:0]     mem_tag,

    // end of program
    input  logic                                 done,
    output logic                                 flush_finished
);
    import dcache_pkg::*;

    logic                  hit;
    cache_block_t          block;
    logic [OFFSET_W-1:0]   offset;
    mem_size_t             size;
    logic                  write;

    line_fill_if #(.N_LINES(N_LINES)) fill_bus ();

    line_store #(.N_LINES(N_LINES)) u_line_store (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .stall     (stall),
        .fill      (fill_bus.store),
        .hit       (hit),
        .block     (block),
        .offset    (offset),
        .size      (size),
        .write     (write)
    );

    miss_handler #(.N_LINES(N_LINES)) u_miss_handler (
        .clock          (clock),
        .reset          (reset),
        .done           (done),
        .mem_response   (mem_response),
        .mem_rdata      (mem_rdata),
        .mem_tag        (mem_tag),
        .stall          (stall),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .flush_finished (flush_finished),
        .fill           (fill_bus.handler)
    );

    load_align u_load_align (
        .clock      (clock),
        .reset      (reset),
        .hit        (hit),
        .block      (block),
        .offset     (offset),
        .size       (size),
        .write      (write),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

endmodule

/* test/mem_model.sv */
`timescale 1ns/10ps

module mem_model (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 throttle,   // accept rarely while high
    input  dcache_pkg::mem_cmd_t                 mem_command,
    input  logic [dcache_pkg::ADDR_W-1:0]        mem_addr,
    input  logic [dcache_pkg::BLOCK_W-1:0]       mem_wdata,
    output logic [dcache_pkg::MEM_TAG_W-1:0]     mem_response,
    output logic [dcache_pkg::BLOCK_W-1:0]       mem_rdata,
    output logic [dcache_pkg::MEM_TAG_W-1:0]     mem_tag
);
    import dcache_pkg::*;

    logic [63:0] lines [logic [31:0]];  // only lines that were stored
    int          seed = 32'h25b1;
    int          protocol_errors = 0;

    logic        accept_now;
    logic [3:0]  next_tag;

    // command seen last cycle without acceptance
    logic        held;
    mem_cmd_t    held_cmd;
    logic [31:0] held_addr;
    logic [63:0] held_wdata;

    // the one outstanding load
    logic        pend_valid;
    logic [3:0]  pend_tag;
    logic [31:0] pend_addr;
    int          pend_wait;

    // untouched memory: every word holds its own byte address xor a marker
    function automatic logic [63:0] read_line(input logic [31:0] base);
        if (lines.exists(base)) begin
            return lines[base];
        end
        return {(base + 32'd4) ^ 32'h5a5a0000, base ^ 32'h5a5a0000};
    endfunction

    assign mem_response = (mem_command != BUS_NONE && accept_now) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            accept_now <= 1'b0;
            next_tag   <= 4'h1;
            held       <= 1'b0;
            pend_valid <= 1'b0;
            mem_tag    <= '0;
            mem_rdata  <= '0;
        end else begin
            if (throttle) begin
                accept_now <= (($random(seed) & 3) == 0);
            end else begin
                accept_now <= (($random(seed) & 3) != 0);
            end
            if (held && (mem_command !== held_cmd || mem_addr !== held_addr ||
                         mem_wdata !== held_wdata)) begin
                protocol_errors++;
                $display("memory command changed before it was accepted at %0t", $time);
            end
            held       <= (mem_command != BUS_NONE) && (mem_response == '0);
            held_cmd   <= mem_command;
            held_addr  <= mem_addr;
            held_wdata <= mem_wdata;
            mem_tag    <= '0;
            if (mem_response != '0) begin
                next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;  // never zero
                if (mem_command == BUS_STORE) begin
                    lines[mem_addr] = mem_wdata;
                end else begin
                    pend_valid <= 1'b1;
                    pend_tag   <= mem_response;
                    pend_addr  <= mem_addr;
                    pend_wait  <= 2 + ($unsigned($random(seed)) % 5);
                end
            end
            if (pend_valid) begin
                if (pend_wait <= 1) begin
                    mem_tag    <= pend_tag;
                    mem_rdata  <= read_line(pend_addr);
                    pend_valid <= 1'b0;
                end else begin
                    pend_wait <= pend_wait - 1;
                end
            end
        end
    end

endmodule

/* test/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int BURST_LEN   = 40;
    localparam int N_REQUESTS  = 12 + BURST_LEN;
    localparam int RESP_LIMIT  = 500;    // cycles per request
    localparam int FLUSH_LIMIT = 2000;   // cycles for the flush walk

    logic        clock;
    logic        reset;
    logic        req_valid;
    logic        req_write;
    mem_size_t   req_size;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        stall;
    logic        resp_valid;
    logic [31:0] resp_data;
    mem_cmd_t    mem_command;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [3:0]  mem_response;
    logic [63:0] mem_rdata;
    logic [3:0]  mem_tag;
    logic        done;
    logic        flush_finished;
    logic        throttle;

    int          seed = 32'h25b1;
    int          errors = 0;
    int          store_count = 0;
    logic [31:0] last_store_addr;
    logic [63:0] shadow [logic [31:0]];  // lines written by the testbench
    logic        dirty_set [logic [31:0]];  // lines not yet written back

    dcache_top #(.N_LINES(32)) u_dut (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_size       (req_size),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .stall          (stall),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_response   (mem_response),
        .mem_rdata      (mem_rdata),
        .mem_tag        (mem_tag),
        .done           (done),
        .flush_finished (flush_finished)
    );

    mem_model u_mem (
        .clock        (clock),
        .reset        (reset),
        .throttle     (throttle),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_tag      (mem_tag)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:3], 3'b000};
    endfunction

    function automatic logic [63:0] shadow_line(input logic [31:0] addr);
        logic [31:0] base;
        base = line_of(addr);
        if (shadow.exists(base)) begin
            return shadow[base];
        end
        return {(base + 32'd4) ^ 32'h5a5a0000, base ^ 32'h5a5a0000};
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr, input mem_size_t sz);
        logic [63:0] shifted;
        shifted = shadow_line(addr) >> (8 * addr[2:0]);
        case (sz)
            BYTE:    return {24'h0, shifted[7:0]};
            HALF:    return {16'h0, shifted[15:0]};
            default: return shifted[31:0];
        endcase
    endfunction

    function automatic void shadow_store(input logic [31:0] addr, input mem_size_t sz,
                                         input logic [31:0] data);
        logic [63:0] mask;
        logic [63:0] line;
        case (sz)
            BYTE:    mask = 64'hff;
            HALF:    mask = 64'hffff;
            default: mask = 64'hffff_ffff;
        endcase
        line = shadow_line(addr);
        line = (line & ~(mask << (8 * addr[2:0]))) | (({32'h0, data} & mask) << (8 * addr[2:0]));
        shadow[line_of(addr)] = line;
    endfunction

    // one request, waits for its response and checks the data
    task automatic access(input logic wr, input mem_size_t sz, input logic [31:0] addr,
                          input logic [31:0] wdata, output int cycles, output logic saw_stall);
        logic [31:0] expected;
        expected = wr ? 32'h0 : expected_load(addr, sz);
        while (stall) begin
            @(posedge clock);
            #1;
        end
        req_valid = 1'b1;
        req_write = wr;
        req_size  = sz;
        req_addr  = addr;
        req_wdata = wdata;
        if (wr) begin
            shadow_store(addr, sz, wdata);
            dirty_set[line_of(addr)] = 1'b1;
        end
        @(posedge clock);
        #1;
        req_valid = 1'b0;
        cycles    = 1;
        saw_stall = 1'b0;
        while (!resp_valid && cycles < RESP_LIMIT) begin
            saw_stall = saw_stall | stall;
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!resp_valid) begin
            errors++;
            $display("no response to the request at address %h", addr);
        end else if (resp_data !== expected) begin
            errors++;
            $display("[FAIL] resp_data at %h: got %h, expected %h", addr, resp_data, expected);
        end
    endtask

    // watches the memory port for written back lines
    always @(posedge clock) begin
        if (!reset && mem_command == BUS_STORE && mem_response != '0) begin
            store_count++;
            last_store_addr = mem_addr;
            if (!dirty_set.exists(mem_addr)) begin
                errors++;
                $display("clean line %h was stored to memory", mem_addr);
            end else begin
                dirty_set.delete(mem_addr);
            end
            if (mem_wdata !== shadow_line(mem_addr)) begin
                errors++;
                $display("[FAIL] mem_wdata at %h: got %h, expected %h",
                         mem_addr, mem_wdata, shadow_line(mem_addr));
            end
        end
    end

    task automatic test_reset();
        if (stall !== 1'b0 || resp_valid !== 1'b0 || flush_finished !== 1'b0) begin
            errors++;
            $display("[FAIL] after reset stall %h resp_valid %h flush_finished %h",
                     stall, resp_valid, flush_finished);
        end
        if (mem_command !== BUS_NONE) begin
            errors++;
            $display("[FAIL] mem_command after reset: got %h, expected %h", mem_command, BUS_NONE);
        end
    endtask

    task automatic test_miss_then_hit();
        int   cycles;
        logic saw_stall;
        access(1'b0, WORD, 32'h100, 32'h0, cycles, saw_stall);
        access(1'b0, WORD, 32'h104, 32'h0, cycles, saw_stall);  // same line
        if (cycles != 1 || saw_stall || stall) begin
            errors++;
            $display("hit took %0d cycles or raised stall", cycles);
        end
        @(posedge clock);
        #1;
        if (resp_valid) begin
            errors++;
            $display("resp_valid stayed high for more than one cycle after a hit");
        end
    endtask

    task automatic test_store_sizes();
        int   cycles;
        logic saw_stall;
        access(1'b1, WORD, 32'h200, 32'hdeadbeef, cycles, saw_stall);
        access(1'b1, BYTE, 32'h201, 32'h123456a5, cycles, saw_stall);
        access(1'b1, HALF, 32'h206, 32'h7777cafe, cycles, saw_stall);
        access(1'b0, WORD, 32'h200, 32'h0, cycles, saw_stall);
        access(1'b0, WORD, 32'h204, 32'h0, cycles, saw_stall);
        access(1'b0, HALF, 32'h200, 32'h0, cycles, saw_stall);
        access(1'b0, HALF, 32'h206, 32'h0, cycles, saw_stall);
        access(1'b0, BYTE, 32'h201, 32'h0, cycles, saw_stall);
        access(1'b0, BYTE, 32'h207, 32'h0, cycles, saw_stall);
    endtask

    // 0x1200 maps to the same index as the dirty line at 0x200
    task automatic test_dirty_eviction();
        int   cycles;
        logic saw_stall;
        int   stores_before;
        stores_before = store_count;
        access(1'b0, WORD, 32'h1200, 32'h0, cycles, saw_stall);
        if (store_count != stores_before + 1) begin
            errors++;
            $display("eviction gave %0d stores instead of one", store_count - stores_before);
        end else if (last_store_addr !== 32'h200) begin
            errors++;
            $display("[FAIL] mem_addr of writeback: got %h, expected %h", last_store_addr, 32'h200);
        end
    endtask

    task automatic test_back_pressure();
        int          cycles;
        logic        saw_stall;
        logic [31:0] r;
        logic [31:0] addr;
        mem_size_t   sz;
        throttle = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            r  = $random(seed);
            sz = (r[5:4] == 2'd3) ? WORD : mem_size_t'(r[5:4]);
            // four tags over four indices, offset aligned to the size
            addr = 32'h4000 + (r[9:8] << 8) + (r[11:10] << 3);
            addr[2:0] = r[2:0] & ((sz == WORD) ? 3'b100 : (sz == HALF) ? 3'b110 : 3'b111);
            access(r[6], sz, addr, $random(seed), cycles, saw_stall);
        end
        throttle = 1'b0;
    endtask

    task automatic test_flush();
        int waited;
        while (stall) begin
            @(posedge clock);
            #1;
        end
        done   = 1'b1;
        waited = 0;
        while (!flush_finished && waited < FLUSH_LIMIT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        done = 1'b0;
        if (!flush_finished) begin
            errors++;
            $display("flush_finished did not rise");
        end
        if (dirty_set.num() != 0) begin
            errors++;
            $display("%0d dirty lines were not written back", dirty_set.num());
        end
        foreach (shadow[a]) begin
            if (!u_mem.lines.exists(a)) begin
                errors++;
                $display("line %h never reached memory", a);
            end else if (u_mem.lines[a] !== shadow[a]) begin
                errors++;
                $display("[FAIL] memory line %h: got %h, expected %h", a, u_mem.lines[a], shadow[a]);
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_size  = WORD;
        req_addr  = '0;
        req_wdata = '0;
        done      = 1'b0;
        throttle  = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset();
        test_miss_then_hit();
        test_store_sizes();
        test_dirty_eviction();
        test_back_pressure();
        test_flush();
        $display("errors: %0d, memory protocol errors: %0d", errors, u_mem.protocol_errors);
        if (errors == 0 && u_mem.protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // request budget plus room for the flush walk and reset
    initial begin
        #(N_REQUESTS * 200 + 2000 + 40);
        $display("watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* sim.f */
design/dcache_pkg.sv
design/line_fill_if.sv
design/line_store.sv
design/miss_handler.sv
design/load_align.sv
design/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/line_fill_if.sv
  - design/line_store.sv
  - design/miss_handler.sv
  - design/load_align.sv
  - design/dcache_top.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_dcache.sv
